// File: verilog.f
+incdir+tb
src/pmp_pkg.sv
src/pmp_cfg_legalize.sv
src/pmp_csr_regs.sv
src/pmp_region_match.sv
src/pmp_access_check.sv
src/pmp_top.sv
tb/pmp_tb.sv

// File: Bender.yml
package:
  name: pmp

sources:
  - src/pmp_pkg.sv
  - src/pmp_cfg_legalize.sv
  - src/pmp_csr_regs.sv
  - src/pmp_region_match.sv
  - src/pmp_access_check.sv
  - src/pmp_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/pmp_tb.sv

// File: tb/pmp_vectors.svh
`ifndef PMP_VECTORS_SVH
`define PMP_VECTORS_SVH

// One row per operation with kind, offset or address, data or access and privilege,
// and the expected value. Check rows expect hit, allowed and region, region only on a hit
task automatic build_table();
  // Reset values and unmapped offsets
  vec_q.push_back(read_row(OFS_PMPCFG0, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG1, 32'h0000_0000, RESP_OKAY));
  for (int i = 0; i < PMP_REGIONS; i++) begin
    vec_q.push_back(read_row(csr_addr_t'(8'h40 + 4 * i), 32'h0000_0000, RESP_OKAY));
  end
  vec_q.push_back(read_row(OFS_MSECCFG, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(read_row(8'h08, 32'h0000_0000, RESP_SLVERR));
  vec_q.push_back(write_row(8'h60, 32'hDEAD_BEEF, RESP_SLVERR));

  // Reserved RWX, NA4 and bits 6:5
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0001, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0002, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG0, 32'h0000_0001, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0013, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG0, 32'h0000_0003, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0067, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG0, 32'h0000_0007, RESP_OKAY));

  // pmpaddr0 seen through OFF, NAPOT and OFF again
  vec_q.push_back(write_row(8'h40, 32'hFFFF_FFFF, RESP_OKAY));
  vec_q.push_back(read_row(8'h40, 32'hFFFF_FFFC, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0018, RESP_OKAY));
  vec_q.push_back(read_row(8'h40, 32'hFFFF_FFFF, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(read_row(8'h40, 32'hFFFF_FFFC, RESP_OKAY));

  // Region 1 TOR R over 0x1000..0x1FFF, region 2 NAPOT RW over 0x4000..0x40FF,
  // region 3 NAPOT X over 0x4000..0x4FFF
  vec_q.push_back(write_row(8'h40, 32'h0000_0400, RESP_OKAY));
  vec_q.push_back(write_row(8'h44, 32'h0000_0800, RESP_OKAY));
  vec_q.push_back(write_row(8'h48, 32'h0000_101F, RESP_OKAY));
  vec_q.push_back(write_row(8'h4C, 32'h0000_11FF, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h1C1B_0900, RESP_OKAY));
  vec_q.push_back(check_row(34'h0_0000_1800, ACC_READ, PRIV_U, 1'b1, 1'b1, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_1800, ACC_WRITE, PRIV_U, 1'b1, 1'b0, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_1FFC, ACC_EXEC, PRIV_U, 1'b1, 1'b0, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_1000, ACC_READ, PRIV_U, 1'b1, 1'b1, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_2000, ACC_READ, PRIV_U, 1'b0, 1'b0, 3'd0));
  vec_q.push_back(check_row(34'h0_0000_0FFC, ACC_READ, PRIV_U, 1'b0, 1'b0, 3'd0));
  vec_q.push_back(check_row(34'h0_0000_0FFC, ACC_READ, PRIV_M, 1'b0, 1'b1, 3'd0));
  vec_q.push_back(check_row(34'h0_0000_1800, ACC_WRITE, PRIV_M, 1'b1, 1'b1, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_4010, ACC_READ, PRIV_U, 1'b1, 1'b1, 3'd2));
  vec_q.push_back(check_row(34'h0_0000_4010, ACC_EXEC, PRIV_U, 1'b1, 1'b0, 3'd2));
  vec_q.push_back(check_row(34'h0_0000_4100, ACC_EXEC, PRIV_U, 1'b1, 1'b1, 3'd3));
  vec_q.push_back(check_row(34'h0_0000_4100, ACC_READ, PRIV_U, 1'b1, 1'b0, 3'd3));
  vec_q.push_back(check_row(34'h3_0000_4010, ACC_READ, PRIV_U, 1'b0, 1'b0, 3'd0));

  // RLB first, then lock region 1 and drop RLB again
  vec_q.push_back(write_row(OFS_MSECCFG, 32'h0000_0004, RESP_OKAY));
  vec_q.push_back(read_row(OFS_MSECCFG, 32'h0000_0004, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h1C1B_8900, RESP_OKAY));
  vec_q.push_back(write_row(8'h44, 32'h0000_0900, RESP_OKAY));
  vec_q.push_back(read_row(8'h44, 32'h0000_0900, RESP_OKAY));
  vec_q.push_back(write_row(8'h44, 32'h0000_0800, RESP_OKAY));
  vec_q.push_back(write_row(OFS_MSECCFG, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG0, 32'h1C1B_0F00, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG0, 32'h1C1B_8900, RESP_OKAY));
  vec_q.push_back(write_row(8'h44, 32'h0000_0900, RESP_OKAY));
  vec_q.push_back(read_row(8'h44, 32'h0000_0800, RESP_OKAY));
  vec_q.push_back(write_row(8'h40, 32'h0000_0300, RESP_OKAY));
  vec_q.push_back(read_row(8'h40, 32'h0000_0400, RESP_OKAY));
  vec_q.push_back(check_row(34'h0_0000_1800, ACC_WRITE, PRIV_M, 1'b1, 1'b0, 3'd1));
  vec_q.push_back(check_row(34'h0_0000_1800, ACC_READ, PRIV_M, 1'b1, 1'b1, 3'd1));
  vec_q.push_back(write_row(OFS_MSECCFG, 32'h0000_0004, RESP_OKAY));
  vec_q.push_back(read_row(OFS_MSECCFG, 32'h0000_0000, RESP_OKAY));

  // Sticky MML and its cfg rules on region 4
  vec_q.push_back(write_row(OFS_MSECCFG, 32'h0000_0001, RESP_OKAY));
  vec_q.push_back(write_row(OFS_MSECCFG, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(read_row(OFS_MSECCFG, 32'h0000_0001, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG1, 32'h0000_008C, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG1, 32'h0000_0000, RESP_OKAY));
  vec_q.push_back(write_row(OFS_PMPCFG1, 32'h0000_0002, RESP_OKAY));
  vec_q.push_back(read_row(OFS_PMPCFG1, 32'h0000_0002, RESP_OKAY));
endtask

`endif

// File: tb/pmp_tb.sv
`timescale 1ns/1ps

module pmp_tb
  import pmp_pkg::*;
();

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_CHECK
  } op_e;

  typedef struct packed {
    op_e         op;
    phys_addr_t  addr;
    csr_data_t   data;
    pmp_acc_e    acc;
    priv_e       priv;
    csr_data_t   exp_data;
    logic [1:0]  exp_resp;
    logic        exp_hit;
    logic        exp_allowed;
    region_idx_t exp_region;
  } vec_row_t;

  logic           clk;
  logic           rst_n;
  axi_lite_req_t  axi_req;
  axi_lite_rsp_t  axi_rsp;
  pmp_check_req_t check_req;
  pmp_check_rsp_t check_rsp;

  vec_row_t    vec_q[$];
  logic [31:0] lcg_state;
  int          row_idx;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  pmp_top pmp_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .axi_req_i   (axi_req),
    .axi_rsp_o   (axi_rsp),
    .check_req_i (check_req),
    .check_rsp_o (check_rsp)
  );

  always #4 clk = ~clk;

  function automatic vec_row_t write_row(csr_addr_t ofs, csr_data_t data, logic [1:0] resp);
    vec_row_t row;
    row          = '0;
    row.op       = OP_WRITE;
    row.addr     = phys_addr_t'(ofs);
    row.data     = data;
    row.exp_resp = resp;
    return row;
  endfunction

  function automatic vec_row_t read_row(csr_addr_t ofs, csr_data_t exp, logic [1:0] resp);
    vec_row_t row;
    row          = '0;
    row.op       = OP_READ;
    row.addr     = phys_addr_t'(ofs);
    row.exp_data = exp;
    row.exp_resp = resp;
    return row;
  endfunction

  function automatic vec_row_t check_row(phys_addr_t addr, pmp_acc_e acc, priv_e priv,
                                         logic hit, logic allowed, region_idx_t region);
    vec_row_t row;
    row             = '0;
    row.op          = OP_CHECK;
    row.addr        = addr;
    row.acc         = acc;
    row.priv        = priv;
    row.exp_hit     = hit;
    row.exp_allowed = allowed;
    row.exp_region  = region;
    return row;
  endfunction

  `include "pmp_vectors.svh"

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Back-pressure of 0 to 3 cycles from the upper LCG bits
  function automatic int next_stall();
    lcg_state = lcg_next(lcg_state);
    return int'(lcg_state[31:30]);
  endfunction

  task automatic compare_value(string name, logic [33:0] got, logic [33:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t row %0d %s: expected %h, got %h", $time, row_idx, name, exp, got);
    end
  endtask

  // Tasks start and end on a falling edge, outputs are sampled 1 ns later
  task automatic axi_write(input csr_addr_t ofs, input csr_data_t data,
                           output logic [1:0] resp);
    int stall;
    stall = next_stall();
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = ofs;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    #1;
    while (!(axi_rsp.awready && axi_rsp.wready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b0;
    repeat (stall) @(negedge clk);
    axi_req.bready = 1'b1;
    #1;
    while (!axi_rsp.bvalid) begin
      @(negedge clk);
      #1;
    end
    resp = axi_rsp.bresp;
    @(negedge clk);
    axi_req.bready = 1'b0;
  endtask

  task automatic axi_read(input csr_addr_t ofs, output csr_data_t data,
                          output logic [1:0] resp);
    int stall;
    stall = next_stall();
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = ofs;
    #1;
    while (!axi_rsp.arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    axi_req.arvalid = 1'b0;
    repeat (stall) @(negedge clk);
    axi_req.rready = 1'b1;
    #1;
    while (!axi_rsp.rvalid) begin
      @(negedge clk);
      #1;
    end
    data = axi_rsp.rdata;
    resp = axi_rsp.rresp;
    @(negedge clk);
    axi_req.rready = 1'b0;
  endtask

  // Result is registered, so it is ready one cycle after the request
  task automatic run_check(input phys_addr_t addr, input pmp_acc_e acc, input priv_e priv,
                           output pmp_check_rsp_t rsp);
    check_req = '{valid: 1'b1, addr: addr, acc: acc, priv: priv};
    @(negedge clk);
    check_req.valid = 1'b0;
    rsp = check_rsp;
  endtask

  task automatic apply_row(input vec_row_t row);
    logic [1:0]     resp;
    csr_data_t      data;
    pmp_check_rsp_t rsp;
    case (row.op)
      OP_WRITE: begin
        axi_write(csr_addr_t'(row.addr), row.data, resp);
        compare_value("bresp", resp, row.exp_resp);
      end
      OP_READ: begin
        axi_read(csr_addr_t'(row.addr), data, resp);
        compare_value("rdata", data, row.exp_data);
        compare_value("rresp", resp, row.exp_resp);
      end
      default: begin
        run_check(row.addr, row.acc, row.priv, rsp);
        compare_value("check_rsp.valid", rsp.valid, 1'b1);
        compare_value("check_rsp.hit", rsp.hit, row.exp_hit);
        compare_value("check_rsp.allowed", rsp.allowed, row.exp_allowed);
        if (row.exp_hit) begin
          compare_value("check_rsp.region", rsp.region, row.exp_region);
        end
      end
    endcase
  endtask

  always @(posedge clk) begin
    cycles++;
    if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("Timeout after %0d cycles, row %0d never completed", cycles, row_idx);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    axi_req       = '0;
    axi_req.wstrb = '1;
    check_req     = '0;
    lcg_state     = 32'hdfee_0ad4;
    row_idx       = 0;
    build_table();
    cycle_limit = 8 + 30 * vec_q.size();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (vec_q[i]) begin
      row_idx = i;
      apply_row(vec_q[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src/pmp_top.sv
`timescale 1ns/1ps

module pmp_top
  import pmp_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  axi_lite_req_t  axi_req_i,
  output axi_lite_rsp_t  axi_rsp_o,
  input  pmp_check_req_t check_req_i,
  output pmp_check_rsp_t check_rsp_o
);

  pmp_cfg_t  [PMP_REGIONS-1:0] cfg;
  pmp_addr_t [PMP_REGIONS-1:0] addr;
  logic      [PMP_REGIONS-1:0] match;

  pmp_csr_regs csr_regs_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .axi_req_i (axi_req_i),
    .axi_rsp_o (axi_rsp_o),
    .cfg_o     (cfg),
    .addr_o    (addr),
    .mseccfg_o ()
  );

  // Region 0 takes its TOR base from address zero
  for (genvar i = 0; i < PMP_REGIONS; i++) begin : gen_match
    pmp_region_match region_match_inst (
      .mode_i       (cfg[i].mode),
      .addr_i       (addr[i]),
      .addr_below_i ((i == 0) ? pmp_addr_t'(0) : addr[(i == 0) ? 0 : i-1]),
      .req_addr_i   (check_req_i.addr),
      .match_o      (match[i])
    );
  end

  pmp_access_check access_check_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (check_req_i),
    .match_i (match),
    .cfg_i   (cfg),
    .rsp_o   (check_rsp_o)
  );

endmodule

// File: src/pmp_access_check.sv
`timescale 1ns/1ps

module pmp_access_check
  import pmp_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  pmp_check_req_t              req_i,
  input  logic     [PMP_REGIONS-1:0]  match_i,
  input  pmp_cfg_t [PMP_REGIONS-1:0]  cfg_i,
  output pmp_check_rsp_t              rsp_o
);

  region_idx_t sel_idx;
  pmp_cfg_t    sel_cfg;
  logic        hit;
  logic        perm;
  logic        is_m;
  logic        allowed;

  logic        valid_q;
  logic        allowed_q;
  logic        hit_q;
  region_idx_t region_q;

  // Lowest index wins, so scan downwards and keep the last hit
  always_comb begin
    sel_idx = '0;
    for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        sel_idx = region_idx_t'(i);
      end
    end
  end

  assign hit     = |match_i;
  assign sel_cfg = cfg_i[sel_idx];
  assign is_m    = (req_i.priv == PRIV_M);

  always_comb begin
    case (req_i.acc)
      ACC_READ:  perm = sel_cfg.read;
      ACC_WRITE: perm = sel_cfg.write;
      ACC_EXEC:  perm = sel_cfg.exec;
      default:   perm = 1'b0;
    endcase
  end

  // M mode is only bound by locked entries
  assign allowed = hit ? ((is_m && !sel_cfg.lock) || perm) : is_m;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      allowed_q <= allowed;
      hit_q     <= hit;
      region_q  <= sel_idx;
    end
  end

  assign rsp_o = '{valid: valid_q, allowed: allowed_q, hit: hit_q, region: region_q};

  a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.valid == $past(req_i.valid));

endmodule

// File: src/pmp_region_match.sv
`timescale 1ns/1ps

module pmp_region_match
  import pmp_pkg::*;
(
  input  pmp_mode_e  mode_i,
  input  pmp_addr_t  addr_i,
  input  pmp_addr_t  addr_below_i,
  input  phys_addr_t req_addr_i,
  output logic       match_o
);

  pmp_addr_t word_addr;
  pmp_addr_t top_addr;
  pmp_addr_t base_addr;
  pmp_addr_t napot_mask;
  logic      tor_hit;
  logic      napot_hit;

  // Checked address in words, same scale as pmpaddr
  assign word_addr = req_addr_i[$bits(phys_addr_t)-1:2];

  // Bounds seen through the grain, like the software view
  assign top_addr  = pmp_addr_view(addr_i, mode_i);
  assign base_addr = addr_below_i & ~GRAIN_MASK;

  assign tor_hit = (word_addr >= base_addr) && (word_addr < top_addr);

  // Trailing ones plus the next zero mark the don't-care bits
  // All ones spans the whole space
  assign napot_mask = top_addr ^ (top_addr + pmp_addr_t'(1));
  assign napot_hit  = ((word_addr ^ top_addr) & ~napot_mask) == '0;

  always_comb begin
    case (mode_i)
      PMP_TOR:   match_o = tor_hit;
      PMP_NAPOT: match_o = napot_hit;
      // OFF, and NA4 which legalization keeps out
      default:   match_o = 1'b0;
    endcase
  end

endmodule

// File: src/pmp_csr_regs.sv
`timescale 1ns/1ps

module pmp_csr_regs
  import pmp_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  axi_lite_req_t                axi_req_i,
  output axi_lite_rsp_t                axi_rsp_o,
  output pmp_cfg_t  [PMP_REGIONS-1:0]  cfg_o,
  output pmp_addr_t [PMP_REGIONS-1:0]  addr_o,
  output mseccfg_t                     mseccfg_o
);

  axi_state_e wr_state_q;
  axi_state_e rd_state_q;
  logic       wr_fire;
  logic       rd_fire;

  pmp_cfg_t  [PMP_REGIONS-1:0] cfg_q;
  pmp_cfg_t  [PMP_REGIONS-1:0] cfg_legal;
  pmp_addr_t [PMP_REGIONS-1:0] addr_q;
  pmp_addr_t [PMP_REGIONS-1:0] addr_view;
  mseccfg_t                    msec_q;

  logic [PMP_REGIONS-1:0] lock_vec;
  logic [PMP_REGIONS-1:0] tor_lock_vec;
  logic [PMP_REGIONS-1:0] addr_locked;
  logic [PMP_REGIONS-1:0] cfg_wr_en;
  logic [PMP_REGIONS-1:0] addr_wr_en;
  logic                   msec_wr_en;

  csr_data_t  rd_data;
  csr_data_t  rdata_q;
  logic [1:0] rresp_q;
  logic [1:0] bresp_q;

  function automatic logic ofs_mapped(csr_addr_t ofs);
    logic hit;
    hit = (ofs == OFS_PMPCFG0) || (ofs == OFS_PMPCFG1) || (ofs == OFS_MSECCFG);
    for (int i = 0; i < PMP_REGIONS; i++) begin
      hit |= (ofs == pmpaddr_ofs(i));
    end
    return hit;
  endfunction

  // Write needs both channels, read needs only AR
  assign wr_fire = (wr_state_q == AXI_IDLE) && axi_req_i.awvalid && axi_req_i.wvalid;
  assign rd_fire = (rd_state_q == AXI_IDLE) && axi_req_i.arvalid;

  // A locked TOR entry also guards the base held by the entry below
  assign addr_locked = (lock_vec | (tor_lock_vec >> 1)) & {PMP_REGIONS{!msec_q.rlb}};
  assign msec_wr_en  = wr_fire && (axi_req_i.awaddr == OFS_MSECCFG);

  for (genvar i = 0; i < PMP_REGIONS; i++) begin : gen_region
    assign lock_vec[i]     = cfg_q[i].lock;
    assign tor_lock_vec[i] = cfg_q[i].lock && (cfg_q[i].mode == PMP_TOR);
    assign addr_view[i]    = pmp_addr_view(addr_q[i], cfg_q[i].mode);

    assign cfg_wr_en[i] = wr_fire &&
      (axi_req_i.awaddr == ((i < CFG_PER_WORD) ? OFS_PMPCFG0 : OFS_PMPCFG1));
    assign addr_wr_en[i] = wr_fire && !addr_locked[i] &&
      (axi_req_i.awaddr == pmpaddr_ofs(i));

    pmp_cfg_legalize cfg_legalize_inst (
      .cfg_prev_i    (cfg_q[i]),
      .cfg_attempt_i (pmp_cfg_t'(axi_req_i.wdata[8*(i%CFG_PER_WORD) +: 8])),
      .mseccfg_i     (msec_q),
      .cfg_legal_o   (cfg_legal[i])
    );
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
      msec_q <= '0;
    end else begin
      for (int i = 0; i < PMP_REGIONS; i++) begin
        if (cfg_wr_en[i]) begin
          cfg_q[i] <= cfg_legal[i];
        end
        if (addr_wr_en[i]) begin
          addr_q[i] <= axi_req_i.wdata;
        end
      end
      if (msec_wr_en) begin
        // MML sticks, RLB may not be raised once anything is locked
        msec_q.mml <= msec_q.mml | axi_req_i.wdata[MSECCFG_MML_BIT];
        msec_q.rlb <= axi_req_i.wdata[MSECCFG_RLB_BIT] && (msec_q.rlb || !(|lock_vec));
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (axi_req_i.araddr == OFS_PMPCFG0) begin
      rd_data = cfg_q[CFG_PER_WORD-1:0];
    end else if (axi_req_i.araddr == OFS_PMPCFG1) begin
      rd_data = cfg_q[PMP_REGIONS-1:CFG_PER_WORD];
    end else if (axi_req_i.araddr == OFS_MSECCFG) begin
      rd_data[MSECCFG_MML_BIT] = msec_q.mml;
      rd_data[MSECCFG_RLB_BIT] = msec_q.rlb;
    end
    for (int i = 0; i < PMP_REGIONS; i++) begin
      if (axi_req_i.araddr == pmpaddr_ofs(i)) begin
        rd_data = addr_view[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= AXI_IDLE;
      rd_state_q <= AXI_IDLE;
    end else begin
      if (wr_fire) begin
        wr_state_q <= AXI_RESP;
      end else if ((wr_state_q == AXI_RESP) && axi_req_i.bready) begin
        wr_state_q <= AXI_IDLE;
      end
      if (rd_fire) begin
        rd_state_q <= AXI_RESP;
      end else if ((rd_state_q == AXI_RESP) && axi_req_i.rready) begin
        rd_state_q <= AXI_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= ofs_mapped(axi_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= ofs_mapped(axi_req_i.araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    axi_rsp_o         = '0;
    axi_rsp_o.awready = wr_fire;
    axi_rsp_o.wready  = wr_fire;
    axi_rsp_o.bvalid  = (wr_state_q == AXI_RESP);
    axi_rsp_o.bresp   = bresp_q;
    axi_rsp_o.arready = rd_fire;
    axi_rsp_o.rvalid  = (rd_state_q == AXI_RESP);
    axi_rsp_o.rdata   = rdata_q;
    axi_rsp_o.rresp   = rresp_q;
  end

  assign cfg_o     = cfg_q;
  assign addr_o    = addr_q;
  assign mseccfg_o = msec_q;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axi_rsp_o.bvalid && !axi_req_i.bready |=> axi_rsp_o.bvalid);

  // Without RLB a locked entry keeps its cfg until reset
  for (genvar i = 0; i < PMP_REGIONS; i++) begin : gen_lock_check
    a_lock_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cfg_q[i].lock && !msec_q.rlb |=> $stable(cfg_q[i]));
  end

endmodule

// File: src/pmp_cfg_legalize.sv
`timescale 1ns/1ps

module pmp_cfg_legalize
  import pmp_pkg::*;
(
  input  pmp_cfg_t cfg_prev_i,
  input  pmp_cfg_t cfg_attempt_i,
  input  mseccfg_t mseccfg_i,
  output pmp_cfg_t cfg_legal_o
);

  logic [2:0] attempt_rwx;
  logic [3:0] attempt_lrwx;
  logic       prev_frozen;
  logic       locked_exec;

  assign attempt_rwx  = {cfg_attempt_i.exec, cfg_attempt_i.write, cfg_attempt_i.read};
  assign attempt_lrwx = {cfg_attempt_i.lock, cfg_attempt_i.read,
                         cfg_attempt_i.write, cfg_attempt_i.exec};

  assign prev_frozen = cfg_prev_i.lock && !mseccfg_i.rlb;

  // Locked executable encodings are refused under MML
  assign locked_exec = mseccfg_i.mml && !mseccfg_i.rlb &&
                       (attempt_lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101});

  always_comb begin
    cfg_legal_o = cfg_attempt_i;

    // W without R is reserved, only MML gives it a meaning
    if ((attempt_rwx inside {3'b010, 3'b110}) && !mseccfg_i.mml) begin
      {cfg_legal_o.exec, cfg_legal_o.write, cfg_legal_o.read} =
        {cfg_prev_i.exec, cfg_prev_i.write, cfg_prev_i.read};
    end

    // No NA4 with grains wider than 4 bytes
    if ((PMP_GRANULARITY >= 1) && (cfg_attempt_i.mode == PMP_NA4)) begin
      cfg_legal_o.mode = cfg_prev_i.mode;
    end

    if (prev_frozen) begin
      cfg_legal_o = cfg_prev_i;
    end

    if (locked_exec) begin
      cfg_legal_o = cfg_prev_i;
    end

    cfg_legal_o.zero = 2'b00;
  end

  // Bits 6:5 never reach storage as ones
  a_zero_tied: assert final (cfg_legal_o.zero == 2'b00)
    else $error("pmp_cfg_legalize: reserved cfg bits set");

endmodule

// File: src/pmp_pkg.sv
package pmp_pkg;

  // Region count and grain size (2^(G+2) bytes)
  localparam int PMP_REGIONS     = 8;
  localparam int PMP_GRANULARITY = 2;

  // Register port widths
  localparam int CSR_AW = 8;
  localparam int CSR_DW = 32;

  // Cfg bytes packed into one pmpcfg word
  localparam int CFG_PER_WORD = CSR_DW / 8;

  typedef logic [CSR_AW-1:0]              csr_addr_t;
  typedef logic [CSR_DW-1:0]              csr_data_t;
  typedef logic [31:0]                    pmp_addr_t;
  typedef logic [33:0]                    phys_addr_t;
  typedef logic [$clog2(PMP_REGIONS)-1:0] region_idx_t;

  // Register map
  localparam csr_addr_t OFS_PMPCFG0  = 8'h00;
  localparam csr_addr_t OFS_PMPCFG1  = 8'h04;
  localparam csr_addr_t OFS_PMPADDR0 = 8'h40;
  localparam csr_addr_t OFS_MSECCFG  = 8'h80;

  localparam int MSECCFG_MML_BIT = 0;
  localparam int MSECCFG_RLB_BIT = 2;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Low pmpaddr bits that fall inside one grain
  localparam pmp_addr_t GRAIN_MASK      = pmp_addr_t'((64'd1 << PMP_GRANULARITY) - 1);
  localparam pmp_addr_t NAPOT_ONES_MASK = pmp_addr_t'((64'd1 << (PMP_GRANULARITY - 1)) - 1);

  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  typedef enum logic {
    AXI_IDLE,
    AXI_RESP
  } axi_state_e;

  // Same bit layout as one byte of pmpcfg
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef struct packed {
    logic mml;
    logic rlb;
  } mseccfg_t;

  typedef struct packed {
    logic       valid;
    phys_addr_t addr;
    pmp_acc_e   acc;
    priv_e      priv;
  } pmp_check_req_t;

  typedef struct packed {
    logic        valid;
    logic        allowed;
    logic        hit;
    region_idx_t region;
  } pmp_check_rsp_t;

  typedef struct packed {
    logic                awvalid;
    csr_addr_t           awaddr;
    logic                wvalid;
    csr_data_t           wdata;
    logic [CSR_DW/8-1:0] wstrb;
    logic                bready;
    logic                arvalid;
    csr_addr_t           araddr;
    logic                rready;
  } axi_lite_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    csr_data_t  rdata;
    logic [1:0] rresp;
  } axi_lite_rsp_t;

  function automatic csr_addr_t pmpaddr_ofs(int unsigned idx);
    return OFS_PMPADDR0 + csr_addr_t'(idx << 2);
  endfunction

  // Software view of a stored pmpaddr, also used for matching
  function automatic pmp_addr_t pmp_addr_view(pmp_addr_t addr, pmp_mode_e mode);
    if (mode == PMP_NAPOT) begin
      return addr | NAPOT_ONES_MASK;
    end
    return addr & ~GRAIN_MASK;
  endfunction

endpackage
